/* list.f */
+incdir+common
common/rv_pkg.sv
logic/reg_file.sv
exe/alu.sv
decode/id_stage.sv
exe/exe_stage.sv
logic/rv_exe_top.sv
dv/tb_rv_exe.sv

/* Makefile */
# Verilator build for the decode/execute pipeline testbench

VERILATOR ?= verilator
TOP       ?= tb_rv_exe
VFLAGS    ?= --binary

.PHONY: sim clean

# Build, run, and pass only when the pass line shows up
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f list.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep "TEST PASS" > /dev/null

clean:
	rm -rf obj_dir

/* dv/tb_rv_exe.sv */
`timescale 1ns/1ps
`include "rv_config.svh"

module tb_rv_exe;
	import rv_pkg::*;

	localparam int N_ALU    = 60;
	localparam int N_STREAM = 100;
	localparam int N_WRITES = 32 + 8;  // Full preload plus branch operands
	localparam int N_INSTR  = 2 + 3 + N_ALU + 12 + 16 + 30 + N_STREAM;
	localparam int LIMIT_NS = (N_WRITES + N_INSTR + 10) * 100;

	typedef struct packed {
		logic [31:0] res;
		logic        ov;
		logic        z;
		logic        br;
		logic [1:0]  m2r;
		logic [2:0]  ld;
		logic [1:0]  st;
		logic [31:0] rd2;
		logic        reg_w;
		logic [4:0]  wa;
	} exp_t;

	logic               clk;
	logic               rstn;
	logic [`XLEN-1:0]   instr;
	logic [`XLEN-1:0]   pc;
	logic               wb_en;
	logic [`REG_AW-1:0] wb_addr;
	logic [`XLEN-1:0]   wb_data;
	logic [`XLEN-1:0]   alu_result;
	logic               ov_flag;
	logic               z_flag;
	logic               pcbranch;
	mem_to_reg_e        mem_to_reg_out;
	ld_op_e             ld_op_out;
	st_op_e             st_op_out;
	logic [`XLEN-1:0]   rd2_out;
	logic               reg_w_out;
	logic [`REG_AW-1:0] wr_addr_out;

	logic [31:0] model [32];
	exp_t        exp_q [$];
	string       name_q [$];
	exp_t        id_e, ex_e;
	string       id_n, ex_n;
	logic        id_v = 1'b0;
	logic        ex_v = 1'b0;
	integer      seed = 32'hdc97;
	int          errors = 0;
	int          checks = 0;

	rv_exe_top uut (
		.clk            (clk),
		.rstn           (rstn),
		.instr          (instr),
		.pc             (pc),
		.wb_en          (wb_en),
		.wb_addr        (wb_addr),
		.wb_data        (wb_data),
		.alu_result     (alu_result),
		.ov_flag        (ov_flag),
		.z_flag         (z_flag),
		.pcbranch       (pcbranch),
		.mem_to_reg_out (mem_to_reg_out),
		.ld_op_out      (ld_op_out),
		.st_op_out      (st_op_out),
		.rd2_out        (rd2_out),
		.reg_w_out      (reg_w_out),
		.wr_addr_out    (wr_addr_out)
	);

	always #50 clk = ~clk;

	task automatic check_val(input string test, input string field, input logic [31:0] exp_v,
		input logic [31:0] act_v);
		checks++;
		if (exp_v !== act_v)
		begin
			errors++;
			$display("Fail %s %s: expected %h, actual %h", test, field, exp_v, act_v);
		end
	endtask

	// True signed sum that leaves the 32-bit range
	function automatic logic add_ovf(input logic [31:0] x, input logic [31:0] y);
		longint s;
		s = longint'($signed(x)) + longint'($signed(y));
		return (s > 64'sd2147483647) || (s < -64'sd2147483648);
	endfunction

	// ------------------------------------------------
	// Reference model of decode and execute
	// ------------------------------------------------
	function automatic exp_t exp_exe(input logic [31:0] ins, input logic [31:0] pc_v,
		input logic [31:0] regs [32]);
		logic [31:0] x1, x2, b, r, imm_i, imm_s, imm_u;
		logic [2:0]  f3;
		logic        is_r;
		exp_t        e;
		x1    = regs[ins[19:15]];
		x2    = regs[ins[24:20]];
		f3    = ins[14:12];
		is_r  = (ins[6:0] == 7'h33);
		imm_i = {{20{ins[31]}}, ins[31:20]};
		imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
		imm_u = {ins[31:12], 12'b0};
		e     = '0;
		e.m2r = 2'd2; // No write-back
		e.rd2 = x2;
		e.wa  = ins[11:7];
		r     = x1 + x2; // Bubble still adds rs1 and rs2
		e.ov  = add_ovf(x1, x2);
		case (ins[6:0])
			7'h33, 7'h13:
			begin
				b       = is_r ? x2 : imm_i;
				e.ov    = 1'b0;
				e.reg_w = 1'b1;
				e.m2r   = 2'd0;
				case (f3)
					3'd0:
					begin
						if (is_r && ins[30])
						begin
							r    = x1 - b;
							e.ov = $signed(x1) < $signed(b);
						end
						else
						begin
							r    = x1 + b;
							e.ov = add_ovf(x1, b);
						end
					end
					3'd1: r = x1 << b[4:0];
					3'd2: r = {31'b0, $signed(x1) < $signed(b)};
					3'd3: r = {31'b0, x1 < b};
					3'd4: r = x1 ^ b;
					3'd5:
					begin
						if (ins[30])
							r = $signed(x1) >>> b[4:0];
						else
							r = x1 >> b[4:0];
					end
					3'd6: r = x1 | b;
					default: r = x1 & b;
				endcase
			end
			7'h37, 7'h17, 7'h6f:
			begin
				e.reg_w = 1'b1;
				e.m2r   = 2'd0;
				if (ins[6:0] == 7'h37)
				begin
					r    = imm_u;
					e.ov = add_ovf(32'd0, imm_u);
				end
				else if (ins[6:0] == 7'h17)
				begin
					r    = pc_v + imm_u;
					e.ov = add_ovf(pc_v, imm_u);
				end
				else
				begin
					r    = pc_v + 32'd4; // Link value
					e.ov = add_ovf(pc_v, 32'd4);
				end
			end
			7'h03:
			begin
				r    = x1 + imm_i;
				e.ov = add_ovf(x1, imm_i);
				case (f3)
					3'd0: e.ld = 3'd1;
					3'd1: e.ld = 3'd2;
					3'd2: e.ld = 3'd3;
					3'd4: e.ld = 3'd4;
					3'd5: e.ld = 3'd5;
					default: e.ld = 3'd0;
				endcase
				if (e.ld != 3'd0)
				begin
					e.reg_w = 1'b1;
					e.m2r   = 2'd1;
				end
			end
			7'h23:
			begin
				r    = x1 + imm_s;
				e.ov = add_ovf(x1, imm_s);
				if (f3 < 3'd3)
					e.st = f3[1:0] + 2'd1;
			end
			7'h63:
			begin
				r    = x1 - x2;
				e.ov = f3[1] ? (x1 < x2) : ($signed(x1) < $signed(x2));
				case (f3)
					3'd0: e.br = (x1 == x2);
					3'd1: e.br = (x1 != x2);
					3'd4: e.br = $signed(x1) < $signed(x2);
					3'd5: e.br = $signed(x1) >= $signed(x2);
					3'd6: e.br = x1 < x2;
					3'd7: e.br = x1 >= x2;
					default: e.br = 1'b0;
				endcase
			end
			default: ;
		endcase
		e.res = r;
		e.z   = (r == 32'd0);
		return e;
	endfunction

	task automatic issue(input logic [31:0] ins, input string test);
		logic [31:0] pc_v;
		pc_v       = $random(seed);
		pc_v[1:0]  = 2'b00;
		@(posedge clk);
		#1;
		instr = ins;
		pc    = pc_v;
		wb_en = 1'b0;
		exp_q.push_back(exp_exe(ins, pc_v, model));
		name_q.push_back(test);
	endtask

	// Write port access with a bubble on the instruction input
	task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
		@(posedge clk);
		#1;
		instr   = '0;
		wb_en   = 1'b1;
		wb_addr = addr;
		wb_data = data;
		if (addr != 5'd0)
			model[addr] = data;
	endtask

	function automatic logic [6:0] pick_op(input logic [2:0] sel);
		case (sel)
			3'd0: return 7'h33;
			3'd1: return 7'h13;
			3'd2: return 7'h37;
			3'd3: return 7'h17;
			3'd4: return 7'h6f;
			3'd5: return 7'h03;
			3'd6: return 7'h23;
			default: return 7'h63;
		endcase
	endfunction

	// ------------------------------------------------
	// Compare process
	// ------------------------------------------------
	always @(posedge clk)
	begin
		ex_v <= id_v;
		ex_e <= id_e;
		ex_n <= id_n;
		if (exp_q.size() > 0)
		begin
			id_v <= 1'b1;
			id_e <= exp_q.pop_front();
			id_n <= name_q.pop_front();
		end
		else
			id_v <= 1'b0;
	end

	always @(negedge clk)
	begin
		if (id_v)
			check_val(id_n, "z_flag", 32'(id_e.z), 32'(z_flag));
		if (ex_v)
		begin
			check_val(ex_n, "alu_result", ex_e.res, alu_result);
			check_val(ex_n, "ov_flag", 32'(ex_e.ov), 32'(ov_flag));
			check_val(ex_n, "pcbranch", 32'(ex_e.br), 32'(pcbranch));
			check_val(ex_n, "mem_to_reg", 32'(ex_e.m2r), 32'(mem_to_reg_out));
			check_val(ex_n, "ld_op", 32'(ex_e.ld), 32'(ld_op_out));
			check_val(ex_n, "st_op", 32'(ex_e.st), 32'(st_op_out));
			check_val(ex_n, "rd2_out", ex_e.rd2, rd2_out);
			check_val(ex_n, "reg_w", 32'(ex_e.reg_w), 32'(reg_w_out));
			check_val(ex_n, "wr_addr", 32'(ex_e.wa), 32'(wr_addr_out));
		end
	end

	initial
	begin
		#(LIMIT_NS);
		$display("Timeout: the run did not finish within %0d ns", LIMIT_NS);
		$display("TEST FAIL");
		$finish;
	end

	initial
	begin
		logic [31:0] ins;
		logic [31:0] rv;
		logic [4:0]  pa [5];
		logic [4:0]  pb [5];
		logic [2:0]  f3s [6];
		clk     = 1'b0;
		rstn    = 1'b0;
		instr   = '0;
		pc      = '0;
		wb_en   = 1'b0;
		wb_addr = '0;
		wb_data = '0;
		for (int i = 0; i < 32; i++)
			model[i] = 32'd0;
		repeat (2) @(posedge clk);
		#1;
		rstn = 1'b1;

		// Zero result out of reset sets z
		@(negedge clk);
		check_val("reset", "alu_result", 32'd0, alu_result);
		check_val("reset", "ov_flag", 32'd0, 32'(ov_flag));
		check_val("reset", "z_flag", 32'd1, 32'(z_flag));
		check_val("reset", "pcbranch", 32'd0, 32'(pcbranch));
		check_val("reset", "mem_to_reg", 32'd0, 32'(mem_to_reg_out));
		check_val("reset", "ld_op", 32'd0, 32'(ld_op_out));
		check_val("reset", "st_op", 32'd0, 32'(st_op_out));
		check_val("reset", "rd2_out", 32'd0, rd2_out);
		check_val("reset", "reg_w", 32'd0, 32'(reg_w_out));
		check_val("reset", "wr_addr", 32'd0, 32'(wr_addr_out));

		issue({7'h0, 5'd2, 5'd1, 3'd0, 5'd5, 7'h33}, "read_before_write");

		// The write to x0 must be dropped
		for (int i = 0; i < 32; i++)
			write_reg(5'(i), (i == 31) ? 32'd37 : $random(seed));
		issue({7'h0, 5'd0, 5'd0, 3'd0, 5'd6, 7'h33}, "x0_read");

		// x31 holds 37 which is above the 5-bit shift range
		issue({7'h00, 5'd31, 5'd3, 3'd1, 5'd7, 7'h33}, "sll_masked");
		issue({7'h00, 5'd31, 5'd3, 3'd5, 5'd7, 7'h33}, "srl_masked");
		issue({7'h20, 5'd31, 5'd3, 3'd5, 5'd7, 7'h33}, "sra_masked");

		for (int i = 0; i < N_ALU; i++)
		begin
			ins      = $random(seed);
			ins[6:0] = (i % 2 == 0) ? 7'h33 : 7'h13;
			issue(ins, $sformatf("alu_rand[%0d]", i));
		end

		for (int i = 0; i < 12; i++)
		begin
			ins      = $random(seed);
			ins[6:0] = (i % 3 == 0) ? 7'h37 : ((i % 3 == 1) ? 7'h17 : 7'h6f);
			issue(ins, $sformatf("upper_jal[%0d]", i));
		end

		for (int i = 0; i < 16; i++)
		begin
			ins      = $random(seed);
			ins[6:0] = (i % 2 == 0) ? 7'h03 : 7'h23;
			issue(ins, $sformatf("load_store[%0d]", i));
		end

		// ------------------------------------------------
		// Branches on equal, mixed-sign, less and greater pairs
		// ------------------------------------------------
		write_reg(5'd1, 32'd5);
		write_reg(5'd2, 32'd5);
		write_reg(5'd3, 32'hffff_fffd); // -3 is huge when unsigned
		write_reg(5'd4, 32'd7);
		write_reg(5'd5, 32'd3);
		write_reg(5'd6, 32'd9);
		write_reg(5'd7, 32'd9);
		write_reg(5'd8, 32'd3);
		pa  = '{5'd1, 5'd3, 5'd4, 5'd5, 5'd7};
		pb  = '{5'd2, 5'd4, 5'd3, 5'd6, 5'd8};
		f3s = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
		for (int p = 0; p < 5; p++)
		begin
			for (int k = 0; k < 6; k++)
				issue({7'h0, pb[p], pa[p], f3s[k], 5'h0, 7'h63},
					$sformatf("branch[%0d][%0d]", p, k));
		end

		for (int i = 0; i < N_STREAM; i++)
		begin
			rv       = $random(seed);
			ins      = $random(seed);
			ins[6:0] = pick_op(rv[2:0]);
			issue(ins, $sformatf("stream[%0d]", i));
		end

		// Let the last two instructions drain
		repeat (3) @(posedge clk);
		@(negedge clk);
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

/* logic/rv_exe_top.sv */
`timescale 1ns/1ps
`include "rv_config.svh"

module rv_exe_top (
	input  logic                clk,
	input  logic                rstn,
	input  rv_pkg::instr_t      instr,
	input  logic [`XLEN-1:0]    pc,
	input  logic                wb_en,    // Stands in for write-back
	input  logic [`REG_AW-1:0]  wb_addr,
	input  logic [`XLEN-1:0]    wb_data,
	output logic [`XLEN-1:0]    alu_result,
	output logic                ov_flag,
	output logic                z_flag,
	output logic                pcbranch,
	output rv_pkg::mem_to_reg_e mem_to_reg_out,
	output rv_pkg::ld_op_e      ld_op_out,
	output rv_pkg::st_op_e      st_op_out,
	output logic [`XLEN-1:0]    rd2_out,
	output logic                reg_w_out,
	output logic [`REG_AW-1:0]  wr_addr_out
);
	import rv_pkg::*;

	// id2exe
	alu_op_e          alu_op;
	alu_a_e           alu_a_sel;
	alu_b_e           alu_b_sel;
	br_op_e           br_op;
	logic [`XLEN-1:0] imm, rd1, rd2, pc_q;
	mem_to_reg_e      mem_to_reg;
	ld_op_e           ld_op;
	st_op_e           st_op;
	logic             reg_w;
	logic [`REG_AW-1:0] wr_addr;

	id_stage u_id_stage (
		.clk        (clk),
		.rstn       (rstn),
		.instr      (instr),
		.pc         (pc),
		.wb_en      (wb_en),
		.wb_addr    (wb_addr),
		.wb_data    (wb_data),
		.alu_op     (alu_op),
		.alu_a_sel  (alu_a_sel),
		.alu_b_sel  (alu_b_sel),
		.br_op      (br_op),
		.imm        (imm),
		.rd1        (rd1),
		.rd2        (rd2),
		.pc_q       (pc_q),
		.mem_to_reg (mem_to_reg),
		.ld_op      (ld_op),
		.st_op      (st_op),
		.reg_w      (reg_w),
		.wr_addr    (wr_addr)
	);

	exe_stage u_exe_stage (
		.clk            (clk),
		.rstn           (rstn),
		.alu_op         (alu_op),
		.alu_a_sel      (alu_a_sel),
		.alu_b_sel      (alu_b_sel),
		.br_op          (br_op),
		.imm            (imm),
		.rd1            (rd1),
		.rd2            (rd2),
		.pc_q           (pc_q),
		.mem_to_reg     (mem_to_reg),
		.ld_op          (ld_op),
		.st_op          (st_op),
		.reg_w          (reg_w),
		.wr_addr        (wr_addr),
		.alu_result     (alu_result),
		.ov_flag        (ov_flag),
		.z_flag         (z_flag),
		.pcbranch       (pcbranch),
		.mem_to_reg_out (mem_to_reg_out),
		.ld_op_out      (ld_op_out),
		.st_op_out      (st_op_out),
		.rd2_out        (rd2_out),
		.reg_w_out      (reg_w_out),
		.wr_addr_out    (wr_addr_out)
	);

endmodule

/* exe/exe_stage.sv */
`timescale 1ns/1ps
`include "rv_config.svh"

module exe_stage (
	input  logic                clk,
	input  logic                rstn,
	input  rv_pkg::alu_op_e     alu_op,
	input  rv_pkg::alu_a_e      alu_a_sel,
	input  rv_pkg::alu_b_e      alu_b_sel,
	input  rv_pkg::br_op_e      br_op,
	input  logic [`XLEN-1:0]    imm,
	input  logic [`XLEN-1:0]    rd1,
	input  logic [`XLEN-1:0]    rd2,
	input  logic [`XLEN-1:0]    pc_q,
	input  rv_pkg::mem_to_reg_e mem_to_reg,
	input  rv_pkg::ld_op_e      ld_op,
	input  rv_pkg::st_op_e      st_op,
	input  logic                reg_w,
	input  logic [`REG_AW-1:0]  wr_addr,
	output logic [`XLEN-1:0]    alu_result,
	output logic                ov_flag,
	output logic                z_flag,
	output logic                pcbranch,
	output rv_pkg::mem_to_reg_e mem_to_reg_out,
	output rv_pkg::ld_op_e      ld_op_out,
	output rv_pkg::st_op_e      st_op_out,
	output logic [`XLEN-1:0]    rd2_out,
	output logic                reg_w_out,
	output logic [`REG_AW-1:0]  wr_addr_out
);
	import rv_pkg::*;

	logic [`XLEN-1:0] a, b, result;
	logic             flag;
	logic             br_taken;

	// ------------------------------------------------
	// Operand select
	// ------------------------------------------------
	always_comb
	begin
		case (alu_a_sel)
			A_ZERO:  a = '0;
			A_PC:    a = pc_q;
			default: a = rd1;
		endcase
	end

	always_comb
	begin
		case (alu_b_sel)
			B_SHAMT: b = {{(`XLEN-5){1'b0}}, rd2[4:0]};
			B_IMM:   b = imm;
			B_FOUR:  b = `XLEN'(4);
			default: b = rd2;
		endcase
	end

	alu u_alu (
		.alu_op (alu_op),
		.a      (a),
		.b      (b),
		.result (result),
		.o_flag (flag),
		.z_flag (z_flag)
	);

	// Branch decision from the compare flag and zero flag
	always_comb
	begin
		case (br_op)
			BR_EQ:   br_taken = !flag && z_flag;
			BR_NE:   br_taken = !z_flag;
			BR_LT:   br_taken = flag && !z_flag;
			BR_GE:   br_taken = !flag;
			default: br_taken = 1'b0;
		endcase
	end

	// ------------------------------------------------
	// exe2lsu register
	// ------------------------------------------------
	always_ff @(posedge clk or negedge rstn)
	begin
		if (!rstn)
		begin
			alu_result     <= '0;
			ov_flag        <= 1'b0;
			pcbranch       <= 1'b0;
			mem_to_reg_out <= M2R_ALU;
			ld_op_out      <= LD_NONE;
			st_op_out      <= ST_NONE;
			rd2_out        <= '0;
			reg_w_out      <= 1'b0;
			wr_addr_out    <= '0;
		end
		else
		begin
			alu_result     <= result; // Also the load/store address
			ov_flag        <= flag;
			pcbranch       <= br_taken;
			mem_to_reg_out <= mem_to_reg;
			ld_op_out      <= ld_op;
			st_op_out      <= st_op;
			rd2_out        <= rd2; // Store data
			reg_w_out      <= reg_w;
			wr_addr_out    <= wr_addr;
		end
	end

endmodule

/* decode/id_stage.sv */
`timescale 1ns/1ps
`include "rv_config.svh"

module id_stage (
	input  logic                clk,
	input  logic                rstn,
	input  rv_pkg::instr_t      instr,
	input  logic [`XLEN-1:0]    pc,
	input  logic                wb_en,
	input  logic [`REG_AW-1:0]  wb_addr,
	input  logic [`XLEN-1:0]    wb_data,
	output rv_pkg::alu_op_e     alu_op,
	output rv_pkg::alu_a_e      alu_a_sel,
	output rv_pkg::alu_b_e      alu_b_sel,
	output rv_pkg::br_op_e      br_op,
	output logic [`XLEN-1:0]    imm,
	output logic [`XLEN-1:0]    rd1,
	output logic [`XLEN-1:0]    rd2,
	output logic [`XLEN-1:0]    pc_q,
	output rv_pkg::mem_to_reg_e mem_to_reg,
	output rv_pkg::ld_op_e      ld_op,
	output rv_pkg::st_op_e      st_op,
	output logic                reg_w,
	output logic [`REG_AW-1:0]  wr_addr
);
	import rv_pkg::*;

	localparam logic [6:0] OP_R      = 7'b0110011;
	localparam logic [6:0] OP_I      = 7'b0010011;
	localparam logic [6:0] OP_LUI    = 7'b0110111;
	localparam logic [6:0] OP_AUIPC  = 7'b0010111;
	localparam logic [6:0] OP_JAL    = 7'b1101111;
	localparam logic [6:0] OP_LOAD   = 7'b0000011;
	localparam logic [6:0] OP_STORE  = 7'b0100011;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;

	logic [`XLEN-1:0] rs1_data, rs2_data;
	logic [`XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
	logic [2:0]       f3;

	alu_op_e     d_alu_op;
	alu_a_e      d_a_sel;
	alu_b_e      d_b_sel;
	br_op_e      d_br_op;
	mem_to_reg_e d_m2r;
	ld_op_e      d_ld_op;
	st_op_e      d_st_op;
	logic        d_reg_w;
	logic [`XLEN-1:0] d_imm;

	// funct3 to ALU op for OP and OP-IMM, sub only exists in the register form
	function automatic alu_op_e arith_op(input logic [2:0] fn3, input logic alt, input logic is_reg);
		case (fn3)
			3'b000: arith_op = (alt && is_reg) ? SUB : ADD;
			3'b001: arith_op = SLL;
			3'b010: arith_op = SLT;
			3'b011: arith_op = SLTU;
			3'b100: arith_op = XOR;
			3'b101: arith_op = alt ? SRA : SRL;
			3'b110: arith_op = OR;
			default: arith_op = AND;
		endcase
	endfunction

	reg_file u_reg_file (
		.clk      (clk),
		.rstn     (rstn),
		.rs1_addr (instr.r.rs1),
		.rs2_addr (instr.r.rs2),
		.wr_en    (wb_en),
		.wr_addr  (wb_addr),
		.wr_data  (wb_data),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data)
	);

	assign f3 = instr.r.funct3;

	// ------------------------------------------------
	// Immediate formats
	// ------------------------------------------------
	assign imm_i = {{(`XLEN-12){instr.i.imm12[11]}}, instr.i.imm12};
	assign imm_s = {{(`XLEN-12){instr.r.funct7[6]}}, instr.r.funct7, instr.r.rd};
	assign imm_b = {{(`XLEN-13){instr.r.funct7[6]}}, instr.r.funct7[6], instr.r.rd[0],
		instr.r.funct7[5:0], instr.r.rd[4:1], 1'b0};
	assign imm_u = {instr.r.funct7, instr.r.rs2, instr.r.rs1, instr.r.funct3, 12'b0};
	assign imm_j = {{(`XLEN-21){instr.r.funct7[6]}}, instr.r.funct7[6], instr.r.rs1,
		instr.r.funct3, instr.r.rs2[0], instr.r.funct7[5:0], instr.r.rs2[4:1], 1'b0};

	// ------------------------------------------------
	// Control decode, anything unknown stays a bubble
	// ------------------------------------------------
	always_comb
	begin
		d_alu_op = ADD;
		d_a_sel  = A_RS1;
		d_b_sel  = B_RS2;
		d_br_op  = BR_NONE;
		d_m2r    = M2R_NONE;
		d_ld_op  = LD_NONE;
		d_st_op  = ST_NONE;
		d_reg_w  = 1'b0;
		d_imm    = '0;
		case (instr.r.opcode)
			OP_R:
			begin
				d_alu_op = arith_op(f3, instr.r.funct7[5], 1'b1);
				d_b_sel  = (f3 == 3'b001 || f3 == 3'b101) ? B_SHAMT : B_RS2;
				d_m2r    = M2R_ALU;
				d_reg_w  = 1'b1;
			end
			OP_I:
			begin
				d_alu_op = arith_op(f3, instr.i.imm12[10], 1'b0); // imm[10] picks srai
				d_b_sel  = B_IMM;
				d_imm    = imm_i;
				d_m2r    = M2R_ALU;
				d_reg_w  = 1'b1;
			end
			OP_LUI, OP_AUIPC:
			begin
				d_a_sel = (instr.r.opcode == OP_LUI) ? A_ZERO : A_PC;
				d_b_sel = B_IMM;
				d_imm   = imm_u;
				d_m2r   = M2R_ALU;
				d_reg_w = 1'b1;
			end
			OP_JAL:
			begin
				d_a_sel = A_PC; // Link value pc+4
				d_b_sel = B_FOUR;
				d_imm   = imm_j;
				d_m2r   = M2R_ALU;
				d_reg_w = 1'b1;
			end
			OP_LOAD:
			begin
				d_b_sel = B_IMM;
				d_imm   = imm_i;
				case (f3)
					3'b000: d_ld_op = LB;
					3'b001: d_ld_op = LH;
					3'b010: d_ld_op = LW;
					3'b100: d_ld_op = LBU;
					3'b101: d_ld_op = LHU;
					default: d_ld_op = LD_NONE;
				endcase
				d_reg_w = (d_ld_op != LD_NONE);
				d_m2r   = (d_ld_op != LD_NONE) ? M2R_LOAD : M2R_NONE;
			end
			OP_STORE:
			begin
				d_b_sel = B_IMM;
				d_imm   = imm_s;
				case (f3)
					3'b000: d_st_op = SB;
					3'b001: d_st_op = SH;
					3'b010: d_st_op = SW;
					default: d_st_op = ST_NONE;
				endcase
			end
			OP_BRANCH:
			begin
				d_alu_op = f3[1] ? SUBU : SUB; // bltu and bgeu have funct3[1] set
				d_imm    = imm_b;
				case (f3)
					3'b000: d_br_op = BR_EQ;
					3'b001: d_br_op = BR_NE;
					3'b100, 3'b110: d_br_op = BR_LT;
					3'b101, 3'b111: d_br_op = BR_GE;
					default: d_br_op = BR_NONE;
				endcase
			end
			default: ;
		endcase
	end

	// id2exe register
	always_ff @(posedge clk or negedge rstn)
	begin
		if (!rstn)
		begin
			alu_op     <= ADD;
			alu_a_sel  <= A_RS1;
			alu_b_sel  <= B_RS2;
			br_op      <= BR_NONE;
			imm        <= '0;
			rd1        <= '0;
			rd2        <= '0;
			pc_q       <= '0;
			mem_to_reg <= M2R_ALU;
			ld_op      <= LD_NONE;
			st_op      <= ST_NONE;
			reg_w      <= 1'b0;
			wr_addr    <= '0;
		end
		else
		begin
			alu_op     <= d_alu_op;
			alu_a_sel  <= d_a_sel;
			alu_b_sel  <= d_b_sel;
			br_op      <= d_br_op;
			imm        <= d_imm;
			rd1        <= rs1_data;
			rd2        <= rs2_data;
			pc_q       <= pc;
			mem_to_reg <= d_m2r;
			ld_op      <= d_ld_op;
			st_op      <= d_st_op;
			reg_w      <= d_reg_w;
			wr_addr    <= instr.r.rd; // Raw rd field, qualified by reg_w
		end
	end

endmodule

/* exe/alu.sv */
`timescale 1ns/1ps
`include "rv_config.svh"

module alu (
	input  rv_pkg::alu_op_e  alu_op,
	input  logic [`XLEN-1:0] a,
	input  logic [`XLEN-1:0] b,
	output logic [`XLEN-1:0] result,
	output logic             o_flag,
	output logic             z_flag
);
	import rv_pkg::*;

	logic [`XLEN-1:0] sum, diff;
	logic [4:0]       shamt;
	logic             signed_lt, unsigned_lt, add_ovf;

	assign sum   = a + b;
	assign diff  = a - b;
	assign shamt = b[4:0]; // Only the low bits shift, also for srai

	assign signed_lt   = $signed(a) < $signed(b);
	assign unsigned_lt = a < b;

	// Same-sign operands with a sum of the other sign
	assign add_ovf = (a[`XLEN-1] == b[`XLEN-1]) && (sum[`XLEN-1] != a[`XLEN-1]);

	always_comb
	begin
		case (alu_op)
			ADD:   result = sum;
			SUB:   result = diff;
			SUBU:  result = diff;
			AND:   result = a & b;
			OR:    result = a | b;
			XOR:   result = a ^ b;
			SLL:   result = a << shamt;
			SRL:   result = a >> shamt;
			SRA:   result = $signed(a) >>> shamt;
			SLT:   result = {{(`XLEN-1){1'b0}}, signed_lt};
			SLTU:  result = {{(`XLEN-1){1'b0}}, unsigned_lt};
			PASSB: result = b;
			default: result = '0;
		endcase
	end

	// Compare result for branches, overflow for add
	always_comb
	begin
		case (alu_op)
			SUB:     o_flag = signed_lt;
			SUBU:    o_flag = unsigned_lt;
			ADD:     o_flag = add_ovf;
			default: o_flag = 1'b0;
		endcase
	end

	assign z_flag = (result == '0);

endmodule

/* logic/reg_file.sv */
`timescale 1ns/1ps
`include "rv_config.svh"

module reg_file (
	input  logic              clk,
	input  logic              rstn,
	input  logic [`REG_AW-1:0] rs1_addr,
	input  logic [`REG_AW-1:0] rs2_addr,
	input  logic              wr_en,
	input  logic [`REG_AW-1:0] wr_addr,
	input  logic [`XLEN-1:0]  wr_data,
	output logic [`XLEN-1:0]  rs1_data,
	output logic [`XLEN-1:0]  rs2_data
);

	logic [`XLEN-1:0] regs [`REG_NUM];

	// x0 is never written, so it stays at its reset value of zero
	always_ff @(posedge clk or negedge rstn)
	begin
		if (!rstn)
		begin
			for (int i = 0; i < `REG_NUM; i++)
				regs[i] <= '0;
		end
		else if (wr_en && (wr_addr != '0))
		begin
			regs[wr_addr] <= wr_data;
		end
	end

	// Read ports, no bypass from the write port
	assign rs1_data = regs[rs1_addr];
	assign rs2_data = regs[rs2_addr];

endmodule

/* common/rv_pkg.sv */
package rv_pkg;

	// One instruction word, seen as R-type fields or as I-type fields
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} r;
		struct packed {
			logic [11:0] imm12; // Sign extended by the decoder
			logic [4:0]  rs1;
			logic [2:0]  funct3;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} i;
	} instr_t;

	typedef enum logic [3:0] {
		ADD   = 4'd0,
		SUB   = 4'd1,  // Flag is signed less-than
		SUBU  = 4'd2,  // Flag is unsigned less-than
		AND   = 4'd3,
		OR    = 4'd4,
		XOR   = 4'd5,
		SLL   = 4'd6,
		SRL   = 4'd7,
		SRA   = 4'd8,
		SLT   = 4'd9,
		SLTU  = 4'd10,
		PASSB = 4'd11
	} alu_op_e;

	typedef enum logic [1:0] {A_RS1 = 2'd0, A_ZERO = 2'd1, A_PC = 2'd2} alu_a_e;

	// B_SHAMT keeps only rs2[4:0]
	typedef enum logic [1:0] {B_RS2 = 2'd0, B_SHAMT = 2'd1, B_IMM = 2'd2, B_FOUR = 2'd3} alu_b_e;

	typedef enum logic [2:0] {
		BR_NONE = 3'd0,
		BR_EQ   = 3'd1,
		BR_NE   = 3'd2,
		BR_LT   = 3'd3, // blt and bltu
		BR_GE   = 3'd4  // bge and bgeu
	} br_op_e;

	typedef enum logic [2:0] {LD_NONE = 3'd0, LB, LH, LW, LBU, LHU} ld_op_e;

	typedef enum logic [1:0] {ST_NONE = 2'd0, SB, SH, SW} st_op_e;

	typedef enum logic [1:0] {M2R_ALU = 2'd0, M2R_LOAD = 2'd1, M2R_NONE = 2'd2} mem_to_reg_e;

endpackage

/* common/rv_config.svh */
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// ------------------------------------------------
// Data path
// ------------------------------------------------

`define XLEN 32 // Integer register width

// ------------------------------------------------
// Register file
// ------------------------------------------------

`define REG_NUM 32 // x0..x31
`define REG_AW  5  // Index width for REG_NUM entries

`endif
